//--- flist.f
+incdir+tb
source/sh_pkg.sv
source/sh_regfile.sv
source/sh_decoder.sv
source/sh_alu.sv
source/sh_mem_align.sv
source/sh_core.sv
tb/sh_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the sh_core testbench with Verilator
verilator --binary --timing --assert -f flist.f --top-module sh_core_tb \
	-Mdir obj_dir -o sh_core_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sh_core_sim > sim.log 2>&1
grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } || \
	{ grep -q "STATUS: PASS" sim.log && echo "Simulation passed" && exit 0 || exit 1; }

//--- source/sh_alu.sv
`timescale 1ns/1ps
`default_nettype none

module sh_alu (
	input  sh_pkg::alu_op_t         op,
	input  logic [sh_pkg::XLEN-1:0] a,
	input  logic [sh_pkg::XLEN-1:0] b,
	output logic [sh_pkg::XLEN-1:0] res,
	output logic                    t_out,
	output logic                    t_valid
);

	logic [sh_pkg::XLEN-1:0] sum;
	logic [sh_pkg::XLEN-1:0] diff;

	assign sum = a + b;
	assign diff = a - b;

	// CMP/EQ reuses the subtractor
	assign t_out = (diff == '0);

	always_comb begin
		t_valid = 1'b0;
		case (op)
			sh_pkg::ALU_ADD:   res = sum;
			sh_pkg::ALU_SUB:   res = diff;
			sh_pkg::ALU_AND:   res = a & b;
			sh_pkg::ALU_OR:    res = a | b;
			sh_pkg::ALU_XOR:   res = a ^ b;
			sh_pkg::ALU_CMPEQ: begin
				res = diff;
				t_valid = 1'b1;
			end
			default:           res = b;
		endcase
	end

	always_comb begin
		if (!$isunknown(op)) begin
			assert (op inside {sh_pkg::ALU_ADD, sh_pkg::ALU_SUB, sh_pkg::ALU_AND,
				sh_pkg::ALU_OR, sh_pkg::ALU_XOR, sh_pkg::ALU_CMPEQ, sh_pkg::ALU_PASSB})
			else $error("ALU op %0d is not a defined operation", op);
		end
	end

endmodule

`default_nettype wire

//--- source/sh_core.sv
`timescale 1ns/1ps
`default_nettype none

module sh_core (
	input  logic                    CLK,
	input  logic                    RST_N,
	output logic [sh_pkg::XLEN-1:0] IMEM_A,
	input  logic [sh_pkg::ILEN-1:0] IMEM_D,
	output sh_pkg::bus_req_t        BUS,
	input  logic [sh_pkg::XLEN-1:0] BUS_DI,
	input  logic                    BUS_WAIT
);

	logic [sh_pkg::XLEN-1:0] pc;
	logic [sh_pkg::ILEN-1:0] id_ir;
	logic [sh_pkg::XLEN-1:0] id_pc;
	sh_pkg::ex_stage_t       ex;
	sh_pkg::ma_stage_t       ma;
	sh_pkg::wb_stage_t       wb;
	logic                    t_reg;

	sh_pkg::dec_instr_t      id_deci;
	logic [sh_pkg::XLEN-1:0] rf_a;
	logic [sh_pkg::XLEN-1:0] rf_b;
	logic [sh_pkg::XLEN-1:0] id_imm;
	logic [sh_pkg::XLEN-1:0] br_target;
	logic                    id_t;
	logic                    br_taken;
	logic                    load_use;
	logic                    bus_stall;
	logic [sh_pkg::XLEN-1:0] ex_a;
	logic [sh_pkg::XLEN-1:0] ex_b;
	logic [sh_pkg::XLEN-1:0] alu_res;
	logic                    alu_t;
	logic                    alu_t_valid;
	logic [3:0]              ma_ba;
	logic [sh_pkg::XLEN-1:0] ma_wdata;
	logic [sh_pkg::XLEN-1:0] ma_rdata;
	logic [sh_pkg::XLEN-1:0] wb_value;

	// Whole pipeline freezes on a waiting transfer
	assign bus_stall = BUS.req & BUS_WAIT;

	//******************************
	// IF
	//******************************
	assign IMEM_A = pc;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc <= '0;
			id_ir <= sh_pkg::NOP_OPCODE;
			id_pc <= '0;
		end else if (!bus_stall && !load_use) begin
			pc <= br_taken ? br_target : pc + 32'd2;
			id_ir <= br_taken ? sh_pkg::NOP_OPCODE : IMEM_D;
			id_pc <= pc;
		end
	end

	//******************************
	// ID
	//******************************
	sh_decoder decoder_inst (.ir(id_ir), .deci(id_deci));

	sh_regfile regfile_inst (
		.CLK(CLK), .RST_N(RST_N),
		.ra_n(id_deci.rn), .rb_n(id_deci.rm), .ra_q(rf_a), .rb_q(rf_b),
		.w_n(wb.deci.rn), .w_d(wb_value), .w_e(wb.deci.rn_write && !bus_stall)
	);

	assign id_imm = {{24{id_ir[7]}}, id_ir[7:0]};
	assign br_target = id_pc + 32'd4 + {id_imm[30:0], 1'b0};

	// T from a CMP/EQ still in EX
	assign id_t = (ex.deci.t_write && alu_t_valid) ? alu_t : t_reg;
	assign br_taken = (id_deci.br == sh_pkg::BR_BT && id_t) ||
		(id_deci.br == sh_pkg::BR_BF && !id_t);

	assign load_use = ex.deci.mem_read &&
		((id_deci.rn_read && id_deci.rn == ex.deci.rn) ||
		(id_deci.rm_read && id_deci.rm == ex.deci.rn));

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex <= '{deci: sh_pkg::DEC_NOP, default: '0};
		end else if (!bus_stall) begin
			if (load_use) begin
				ex.deci <= sh_pkg::DEC_NOP;
			end else begin
				ex <= '{deci: id_deci, a: rf_a, b: rf_b, imm: id_imm, pc: id_pc};
			end
		end
	end

	//******************************
	// EX
	//******************************
	function automatic logic [sh_pkg::XLEN-1:0] fwd_operand(
		input logic [sh_pkg::RIDX_W-1:0] idx,
		input logic [sh_pkg::XLEN-1:0]   rf_val,
		input sh_pkg::ma_stage_t         ma_s,
		input sh_pkg::dec_instr_t        wb_deci,
		input logic [sh_pkg::XLEN-1:0]   wb_val
	);
		logic [sh_pkg::XLEN-1:0] val;
		if (ma_s.deci.rn_write && !ma_s.deci.mem_read && ma_s.deci.rn == idx) begin
			val = ma_s.res;
		end else if (wb_deci.rn_write && wb_deci.rn == idx) begin
			val = wb_val;
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	assign ex_a = fwd_operand(ex.deci.rn, ex.a, ma, wb.deci, wb_value);
	assign ex_b = fwd_operand(ex.deci.rm, ex.b, ma, wb.deci, wb_value);

	sh_alu alu_inst (
		.op(ex.deci.alu_op), .a(ex_a),
		.b(ex.deci.imm == sh_pkg::IMM_S8 ? ex.imm : ex_b),
		.res(alu_res), .t_out(alu_t), .t_valid(alu_t_valid)
	);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ma <= '{deci: sh_pkg::DEC_NOP, default: '0};
			t_reg <= 1'b0;
		end else if (!bus_stall) begin
			// Stores address through Rn, loads through Rm
			ma <= '{deci: ex.deci, res: alu_res,
				addr: ex.deci.mem_write ? ex_a : ex_b, wd: ex_b};
			if (ex.deci.t_write && alu_t_valid) begin
				t_reg <= alu_t;
			end
		end
	end

	//******************************
	// MA and WB
	//******************************
	sh_mem_align mem_align_inst (
		.size(ma.deci.mem_size), .addr_lo(ma.addr[1:0]), .wd(ma.wd), .bus_di(BUS_DI),
		.ba(ma_ba), .wdata(ma_wdata), .rdata(ma_rdata)
	);

	assign BUS = '{addr: ma.addr, wdata: ma_wdata, ba: ma_ba, wr: ma.deci.mem_write,
		req: ma.deci.mem_read | ma.deci.mem_write};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wb <= '{deci: sh_pkg::DEC_NOP, default: '0};
		end else if (!bus_stall) begin
			wb <= '{deci: ma.deci, res: ma.res, ld: ma_rdata};
		end
	end

	assign wb_value = wb.deci.mem_read ? wb.ld : wb.res;

	a_wr_needs_req: assert property (@(posedge CLK) disable iff (!RST_N)
		BUS.wr |-> BUS.req);

	a_hold_on_wait: assert property (@(posedge CLK) disable iff (!RST_N)
		BUS.req && BUS_WAIT |=> $stable(IMEM_A) && $stable(id_ir) && $stable(ex) && $stable(ma));

endmodule

`default_nettype wire

//--- source/sh_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module sh_decoder (
	input  logic [sh_pkg::ILEN-1:0] ir,
	output sh_pkg::dec_instr_t      deci
);

	// Top nibble groups of the supported subset
	typedef enum logic [3:0] {
		MJ_STORE_LOGIC = 4'h2,
		MJ_ARITH       = 4'h3,
		MJ_LOAD        = 4'h6,
		MJ_ADDI        = 4'h7,
		MJ_BRANCH      = 4'h8,
		MJ_MOVI        = 4'hE
	} major_t;

	major_t major;

	assign major = major_t'(ir[15:12]);

	always_comb begin
		deci = sh_pkg::DEC_NOP;
		deci.rn = ir[11:8];
		deci.rm = ir[7:4];
		case (major)
			MJ_STORE_LOGIC: begin
				if (ir[3:0] <= 4'h2) begin
					// MOV.x Rm,@Rn
					deci.rn_read = 1'b1;
					deci.rm_read = 1'b1;
					deci.mem_write = 1'b1;
					deci.mem_size = sh_pkg::mem_size_t'(ir[1:0]);
				end else if (ir[3:0] >= 4'h9 && ir[3:0] <= 4'hB) begin
					deci.rn_read = 1'b1;
					deci.rm_read = 1'b1;
					deci.rn_write = 1'b1;
					case (ir[1:0])
						2'b01:   deci.alu_op = sh_pkg::ALU_AND;
						2'b10:   deci.alu_op = sh_pkg::ALU_XOR;
						default: deci.alu_op = sh_pkg::ALU_OR;
					endcase
				end
			end
			MJ_ARITH: begin
				if (ir[3:0] == 4'h0) begin
					deci.rn_read = 1'b1;
					deci.rm_read = 1'b1;
					deci.alu_op = sh_pkg::ALU_CMPEQ;
					deci.t_write = 1'b1;
				end else if (ir[3:0] == 4'h8 || ir[3:0] == 4'hC) begin
					deci.rn_read = 1'b1;
					deci.rm_read = 1'b1;
					deci.rn_write = 1'b1;
					deci.alu_op = ir[2] ? sh_pkg::ALU_ADD : sh_pkg::ALU_SUB;
				end
			end
			MJ_LOAD: begin
				if (ir[3:0] <= 4'h2) begin
					// MOV.x @Rm,Rn
					deci.rm_read = 1'b1;
					deci.rn_write = 1'b1;
					deci.mem_read = 1'b1;
					deci.mem_size = sh_pkg::mem_size_t'(ir[1:0]);
					deci.alu_op = sh_pkg::ALU_PASSB;
				end
			end
			MJ_ADDI: begin
				deci.rn_read = 1'b1;
				deci.rn_write = 1'b1;
				deci.imm = sh_pkg::IMM_S8;
			end
			MJ_BRANCH: begin
				if (ir[11:8] == 4'h9 || ir[11:8] == 4'hB) begin
					deci.imm = sh_pkg::IMM_BR8;
					deci.br = ir[9] ? sh_pkg::BR_BF : sh_pkg::BR_BT;
				end
			end
			MJ_MOVI: begin
				deci.rn_write = 1'b1;
				deci.imm = sh_pkg::IMM_S8;
				deci.alu_op = sh_pkg::ALU_PASSB;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- source/sh_mem_align.sv
`timescale 1ns/1ps
`default_nettype none

module sh_mem_align (
	input  sh_pkg::mem_size_t       size,
	input  logic [1:0]              addr_lo,
	input  logic [sh_pkg::XLEN-1:0] wd,
	input  logic [sh_pkg::XLEN-1:0] bus_di,
	output logic [3:0]              ba,
	output logic [sh_pkg::XLEN-1:0] wdata,
	output logic [sh_pkg::XLEN-1:0] rdata
);

	logic [7:0]  rd_byte;
	logic [15:0] rd_half;

	// Big-endian lanes, offset 0 is the top byte
	assign rd_byte = bus_di[(5'd24 - {addr_lo, 3'b000}) +: 8];
	assign rd_half = addr_lo[1] ? bus_di[15:0] : bus_di[31:16];

	always_comb begin
		case (size)
			sh_pkg::SZ_BYTE: begin
				ba = 4'b1000 >> addr_lo;
				wdata = {4{wd[7:0]}};
				rdata = {{24{rd_byte[7]}}, rd_byte};
			end
			sh_pkg::SZ_WORD: begin
				ba = addr_lo[1] ? 4'b0011 : 4'b1100;
				wdata = {2{wd[15:0]}};
				rdata = {{16{rd_half[15]}}, rd_half};
			end
			default: begin
				ba = 4'b1111;
				wdata = wd;
				rdata = bus_di;
			end
		endcase
	end

	always_comb begin
		if (!$isunknown({size, addr_lo})) begin
			assert ((size != sh_pkg::SZ_WORD || !addr_lo[0]) &&
				(size != sh_pkg::SZ_LONG || addr_lo == 2'b00))
			else $error("Misaligned access, size %0d offset %0d", size, addr_lo);
		end
	end

endmodule

`default_nettype wire

//--- source/sh_pkg.sv
`default_nettype none

package sh_pkg;

	localparam int XLEN    = 32;
	localparam int ILEN    = 16;
	localparam int REG_NUM = 16;
	localparam int RIDX_W  = 4;

	localparam logic [ILEN-1:0] NOP_OPCODE = 16'h0009;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_CMPEQ,
		ALU_PASSB
	} alu_op_t;

	typedef enum logic [1:0] {
		IMM_NONE,
		IMM_S8,
		IMM_BR8
	} imm_t;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_BT,
		BR_BF
	} br_t;

	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_WORD,
		SZ_LONG
	} mem_size_t;

	typedef struct packed {
		logic [RIDX_W-1:0] rn;
		logic [RIDX_W-1:0] rm;
		logic              rn_read;
		logic              rm_read;
		logic              rn_write;
		alu_op_t           alu_op;
		imm_t              imm;
		logic              mem_read;
		logic              mem_write;
		mem_size_t         mem_size;
		br_t               br;
		logic              t_write;
	} dec_instr_t;

	// Decode of NOP and of every unknown opcode
	localparam dec_instr_t DEC_NOP = '{
		rn: '0, rm: '0,
		rn_read: 1'b0, rm_read: 1'b0, rn_write: 1'b0,
		alu_op: ALU_ADD, imm: IMM_NONE,
		mem_read: 1'b0, mem_write: 1'b0, mem_size: SZ_BYTE,
		br: BR_NONE, t_write: 1'b0
	};

	//******************************
	// Pipeline stage registers
	//******************************
	typedef struct packed {
		dec_instr_t      deci;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] pc;
	} ex_stage_t;

	typedef struct packed {
		dec_instr_t      deci;
		logic [XLEN-1:0] res;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wd;
	} ma_stage_t;

	typedef struct packed {
		dec_instr_t      deci;
		logic [XLEN-1:0] res;
		logic [XLEN-1:0] ld;
	} wb_stage_t;

	typedef struct packed {
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
		logic [3:0]      ba;
		logic            wr;
		logic            req;
	} bus_req_t;

endpackage

`default_nettype wire

//--- source/sh_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module sh_regfile (
	input  logic                      CLK,
	input  logic                      RST_N,
	input  logic [sh_pkg::RIDX_W-1:0] ra_n,
	input  logic [sh_pkg::RIDX_W-1:0] rb_n,
	output logic [sh_pkg::XLEN-1:0]   ra_q,
	output logic [sh_pkg::XLEN-1:0]   rb_q,
	input  logic [sh_pkg::RIDX_W-1:0] w_n,
	input  logic [sh_pkg::XLEN-1:0]   w_d,
	input  logic                      w_e
);

	logic [sh_pkg::XLEN-1:0] regs [sh_pkg::REG_NUM];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < sh_pkg::REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (w_e) begin
			regs[w_n] <= w_d;
		end
	end

	// WB write is seen by ID in the same cycle
	assign ra_q = (w_e && w_n == ra_n) ? w_d : regs[ra_n];
	assign rb_q = (w_e && w_n == rb_n) ? w_d : regs[rb_n];

endmodule

`default_nettype wire

//--- tb/sh_isa_model.svh
`ifndef SH_ISA_MODEL_SVH
`define SH_ISA_MODEL_SVH

// Instruction-level model, one instruction per step, no pipeline
function automatic void run_model();
	logic [31:0] r [16];
	logic [31:0] mem [256];
	logic [31:0] pc;
	logic [31:0] pc_next;
	logic [31:0] simm;
	logic [31:0] ea;
	logic [31:0] w;
	logic [15:0] ir;
	logic [3:0]  n;
	logic [3:0]  m;
	logic        t;
	int          k;
	int          steps;
	sh_pkg::bus_req_t s;
	for (int i = 0; i < 16; i++) begin
		r[i] = '0;
	end
	for (int i = 0; i < 256; i++) begin
		mem[i] = dmem_init[i];
	end
	pc = '0;
	t = 1'b0;
	for (steps = 0; steps < 1024; steps++) begin
		ir = imem[pc[8:1]];
		n = ir[11:8];
		m = ir[7:4];
		simm = {{24{ir[7]}}, ir[7:0]};
		pc_next = pc + 32'd2;
		ea = (ir[15:12] == 4'h2) ? r[n] : r[m];
		k = ea[1:0];
		if (ir[15:12] == 4'hE) begin
			r[n] = simm;
		end else if (ir[15:12] == 4'h7) begin
			r[n] = r[n] + simm;
		end else if (ir[15:12] == 4'h3 && ir[3:0] == 4'h0) begin
			t = (r[n] == r[m]);
		end else if (ir[15:12] == 4'h3 && ir[3:0] == 4'h8) begin
			r[n] = r[n] - r[m];
		end else if (ir[15:12] == 4'h3 && ir[3:0] == 4'hC) begin
			r[n] = r[n] + r[m];
		end else if (ir[15:12] == 4'h2 && ir[3:0] == 4'h9) begin
			r[n] = r[n] & r[m];
		end else if (ir[15:12] == 4'h2 && ir[3:0] == 4'hA) begin
			r[n] = r[n] ^ r[m];
		end else if (ir[15:12] == 4'h2 && ir[3:0] == 4'hB) begin
			r[n] = r[n] | r[m];
		end else if (ir[15:12] == 4'h2 && ir[3:0] <= 4'h2) begin
			s.addr = ea;
			s.wr = 1'b1;
			s.req = 1'b1;
			if (ir[1:0] == 2'd0) begin
				s.ba = 4'b0001 << (3 - k);
				s.wdata = {4{r[m][7:0]}};
			end else if (ir[1:0] == 2'd1) begin
				s.ba = ea[1] ? 4'b0011 : 4'b1100;
				s.wdata = {2{r[m][15:0]}};
			end else begin
				s.ba = 4'b1111;
				s.wdata = r[m];
			end
			for (int j = 0; j < 4; j++) begin
				if (s.ba[3-j]) begin
					mem[ea[9:2]][31-8*j -: 8] = s.wdata[31-8*j -: 8];
				end
			end
			exp_q.push_back(s);
			if (ea == MARKER_ADDR) begin
				return;
			end
		end else if (ir[15:12] == 4'h6 && ir[3:0] <= 4'h2) begin
			w = mem[ea[9:2]];
			if (ir[1:0] == 2'd0) begin
				r[n] = {{24{w[31-8*k]}}, w[31-8*k -: 8]};
			end else if (ir[1:0] == 2'd1) begin
				r[n] = ea[1] ? {{16{w[15]}}, w[15:0]} : {{16{w[31]}}, w[31:16]};
			end else begin
				r[n] = w;
			end
		end else if (ir[15:12] == 4'h8 && ((n == 4'h9 && t) || (n == 4'hB && !t))) begin
			pc_next = pc + 32'd4 + {simm[30:0], 1'b0};
		end
		pc = pc_next;
	end
endfunction

`endif

//--- tb/sh_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sh_core_tb;

	localparam logic [31:0] MARKER_ADDR = 32'hFFFF_FFFC;

	logic             CLK;
	logic             RST_N;
	logic [31:0]      IMEM_A;
	logic [15:0]      IMEM_D;
	sh_pkg::bus_req_t BUS;
	logic [31:0]      BUS_DI;
	logic             BUS_WAIT;

	logic [15:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] dmem_init [256];
	logic [15:0] lfsr_state = 16'd70;
	int          prog_len = 0;
	int          cycles = 0;
	int          wait_left = 0;
	int          store_idx = 0;
	sh_pkg::bus_req_t exp_q [$];

	`include "sh_isa_model.svh"

	sh_core sh_core_inst (
		.CLK(CLK), .RST_N(RST_N), .IMEM_A(IMEM_A), .IMEM_D(IMEM_D),
		.BUS(BUS), .BUS_DI(BUS_DI), .BUS_WAIT(BUS_WAIT)
	);

	assign IMEM_D = imem[IMEM_A[8:1]];
	assign BUS_DI = dmem[BUS.addr[9:2]];

	// Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_step();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 16'hB400;
		end
		return lsb;
	endfunction

	function automatic logic [7:0] rand_bits(input int nbits);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			v = {v[6:0], lfsr_step()};
		end
		return v;
	endfunction

	task automatic emit(input logic [15:0] op);
		imem[prog_len] = op;
		prog_len++;
	endtask

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_store(input sh_pkg::bus_req_t got, input sh_pkg::bus_req_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Fail at %0t: store %0d got %h %h %b, expected %h %h %b",
				$time, store_idx, got.addr, got.wdata, got.ba, exp.addr, exp.wdata, exp.ba));
		end
	endtask

	task automatic check_idle(input sh_pkg::bus_req_t got, input logic [31:0] ia);
		if (got.req !== 1'b0 || got.wr !== 1'b0 || ia !== 32'd0) begin
			fail_now($sformatf("Fail at %0t: reset state req %b wr %b IMEM_A %h",
				$time, got.req, got.wr, ia));
		end
	endtask

	task automatic build_program();
		// Arithmetic and logic chains
		emit({8'hE1, rand_bits(8)});
		emit({8'hE2, rand_bits(8)});
		emit({8'hE3, rand_bits(8)});
		emit(16'h321C);
		emit(16'h3238);
		emit(16'h2129);
		emit(16'h212A);
		emit(16'h213B);
		emit({8'h71, rand_bits(8)});
		emit(16'hE840);
		emit(16'h2812);
		emit(16'h7804);
		emit(16'h2822);
		emit(16'h7804);
		// Byte stores at each offset, then words and a long
		for (int i = 0; i < 4; i++) begin
			emit(16'h2820);
			emit(16'h7801);
		end
		emit(16'h2811);
		emit(16'h7802);
		emit(16'h2811);
		emit(16'h7802);
		emit(16'h2812);
		// Loads used by the next instruction
		emit(16'hEA00);
		emit(16'hEB60);
		for (int i = 0; i < 4; i++) begin
			emit(16'h63A0);
			emit(16'h2B32);
			emit(16'h7B04);
			emit(16'h7A01);
		end
		for (int i = 0; i < 2; i++) begin
			emit(16'h63A1);
			emit(16'h2B32);
			emit(16'h7B04);
			emit(16'h7A02);
		end
		emit(16'h63A2);
		emit(16'h333C);
		emit(16'h2B32);
		emit(16'h7B04);
		emit(16'hE540);
		emit(16'h6452);
		emit(16'h2B42);
		emit(16'h7B04);
		// CMP/EQ then BT or BF over one store
		for (int i = 0; i < 6; i++) begin
			emit(rand_bits(1) ? 16'h3110 : 16'h3120);
			emit(rand_bits(1) ? 16'h8900 : 16'h8B00);
			emit(16'h2B12);
			emit(16'h7B04);
		end
		emit(16'hECFC);
		emit(16'h2C12);
	endtask

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		RST_N <= 1'b0;
		BUS_WAIT <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = sh_pkg::NOP_OPCODE;
			dmem_init[i] = i * 32'h9E37_79B1 + 32'h0080_7F80;
			dmem[i] <= dmem_init[i];
		end
		build_program();
		run_model();
		repeat (2) @(posedge CLK);
		check_idle(BUS, IMEM_A);
		repeat (3) @(posedge CLK);
		RST_N <= 1'b1;
	end

	//******************************
	// Data memory and wait states
	//******************************
	always @(posedge CLK) begin
		if (RST_N && BUS.req) begin
			if (BUS_WAIT) begin
				wait_left = wait_left - 1;
				BUS_WAIT <= (wait_left > 0);
			end else begin
				wait_left = rand_bits(2);
				BUS_WAIT <= (wait_left > 0);
				if (BUS.wr) begin
					for (int j = 0; j < 4; j++) begin
						if (BUS.ba[3-j]) begin
							dmem[BUS.addr[9:2]][31-8*j -: 8] <= BUS.wdata[31-8*j -: 8];
						end
					end
				end
			end
		end
	end

	// Store comparison
	always @(posedge CLK) begin
		if (RST_N && BUS.req && BUS.wr && !BUS_WAIT) begin
			if (store_idx >= exp_q.size()) begin
				fail_now($sformatf("Unexpected extra store to address %h at time %0t",
					BUS.addr, $time));
			end
			check_store(BUS, exp_q[store_idx]);
			store_idx++;
			if (BUS.addr == MARKER_ADDR) begin
				if (store_idx == exp_q.size()) begin
					$display("STATUS: PASS");
					$finish;
				end else begin
					fail_now($sformatf("Marker store reached after %0d of %0d stores",
						store_idx, exp_q.size()));
				end
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > 20 * prog_len + 50) begin
			fail_now($sformatf("Timeout, no marker store after %0d cycles", cycles));
		end
	end

endmodule

`default_nettype wire
